//--- source/decode_pkg.sv
// Decode stage shared types: opcodes, operation and format codes, instruction views
`default_nettype none

package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // NOP sits at zero so a cleared word reads as a bubble
    typedef enum logic [5:0] {
        NOP, LUI, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        ECALL, EBREAK, MRET, SRET, WFI, INVALID
    } iop_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } fmt_e;

    ////////////////////////////////////////
    // Field layouts of one instruction word
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // Registered result handed to execute
    typedef struct packed {
        logic [XLEN-1:0] first_operand;
        logic [XLEN-1:0] second_operand;
        logic [XLEN-1:0] third_operand;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instruction;
        iop_e            op;
        logic            exc_illegal;
        logic            exc_misaligned;
        logic            exc_access_fault;
    } decode_out_t;

endpackage

`default_nettype wire

//--- source/op_decoder.sv
// Operation decoder: maps opcode and function fields to operation, format and legality
`timescale 1ns/1ps
`default_nettype none

module op_decoder
    import decode_pkg::*;
(
    input  instr_u instr_i,
    output iop_e   op_o,
    output fmt_e   fmt_o,
    output logic   illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    iop_e       dec_branch;
    iop_e       dec_load;
    iop_e       dec_store;
    iop_e       dec_op_imm;
    iop_e       dec_op;
    iop_e       dec_system;
    iop_e       class_op;
    logic       known_opc;

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;

    ////////////////////////////////////////
    // Per-class decode
    ////////////////////////////////////////

    always_comb begin
        unique case (funct3)
            3'b000:  dec_branch = BEQ;
            3'b001:  dec_branch = BNE;
            3'b100:  dec_branch = BLT;
            3'b101:  dec_branch = BGE;
            3'b110:  dec_branch = BLTU;
            3'b111:  dec_branch = BGEU;
            default: dec_branch = INVALID;
        endcase
        unique case (funct3)
            3'b000:  dec_load = LB;
            3'b001:  dec_load = LH;
            3'b010:  dec_load = LW;
            3'b100:  dec_load = LBU;
            3'b101:  dec_load = LHU;
            default: dec_load = INVALID;
        endcase
        unique case (funct3)
            3'b000:  dec_store = SB;
            3'b001:  dec_store = SH;
            3'b010:  dec_store = SW;
            default: dec_store = INVALID;
        endcase
    end

    // Only the shifts look at funct7 here
    always_comb begin
        unique case ({funct7, funct3}) inside
            10'b???????000: dec_op_imm = ADD;
            10'b0000000001: dec_op_imm = SLL;
            10'b???????010: dec_op_imm = SLT;
            10'b???????011: dec_op_imm = SLTU;
            10'b???????100: dec_op_imm = XOR;
            10'b0000000101: dec_op_imm = SRL;
            10'b0100000101: dec_op_imm = SRA;
            10'b???????110: dec_op_imm = OR;
            10'b???????111: dec_op_imm = AND;
            default:        dec_op_imm = INVALID;
        endcase
    end

    // Register ops, M extension in the funct7 = 1 rows
    always_comb begin
        unique case ({funct7, funct3})
            10'b0000000000: dec_op = ADD;
            10'b0100000000: dec_op = SUB;
            10'b0000000001: dec_op = SLL;
            10'b0000000010: dec_op = SLT;
            10'b0000000011: dec_op = SLTU;
            10'b0000000100: dec_op = XOR;
            10'b0000000101: dec_op = SRL;
            10'b0100000101: dec_op = SRA;
            10'b0000000110: dec_op = OR;
            10'b0000000111: dec_op = AND;
            10'b0000001000: dec_op = MUL;
            10'b0000001001: dec_op = MULH;
            10'b0000001010: dec_op = MULHSU;
            10'b0000001011: dec_op = MULHU;
            10'b0000001100: dec_op = DIV;
            10'b0000001101: dec_op = DIVU;
            10'b0000001110: dec_op = REM;
            10'b0000001111: dec_op = REMU;
            default:        dec_op = INVALID;
        endcase
    end

    always_comb begin
        unique case (instr_i[31:7]) inside
            25'b0000000000000000000000000: dec_system = ECALL;
            25'b0000000000010000000000000: dec_system = EBREAK;
            25'b0001000000100000000000000: dec_system = SRET;
            25'b0011000000100000000000000: dec_system = MRET;
            25'b0001000001010000000000000: dec_system = WFI;
            25'b?????????????????001?????: dec_system = CSRRW;
            25'b?????????????????010?????: dec_system = CSRRS;
            25'b?????????????????011?????: dec_system = CSRRC;
            25'b?????????????????101?????: dec_system = CSRRWI;
            25'b?????????????????110?????: dec_system = CSRRSI;
            25'b?????????????????111?????: dec_system = CSRRCI;
            default:                       dec_system = INVALID;
        endcase
    end

    // Opcode select, anything unlisted (vector, FP, custom) is not known
    always_comb begin
        known_opc = 1'b1;
        unique case (opcode)
            OPC_LUI:      class_op = LUI;
            OPC_AUIPC:    class_op = ADD;
            OPC_JAL:      class_op = JAL;
            OPC_JALR:     class_op = JALR;
            OPC_BRANCH:   class_op = dec_branch;
            OPC_LOAD:     class_op = dec_load;
            OPC_STORE:    class_op = dec_store;
            OPC_OP_IMM:   class_op = dec_op_imm;
            OPC_OP:       class_op = dec_op;
            OPC_MISC_MEM: class_op = (funct3 == 3'b000) ? NOP : INVALID;
            OPC_SYSTEM:   class_op = dec_system;
            default: begin
                class_op  = NOP;
                known_opc = 1'b0;
            end
        endcase
    end

    assign op_o      = known_opc ? class_op : INVALID;
    assign illegal_o = ~known_opc | (class_op == INVALID);

    always_comb begin
        unique case (opcode[6:2])
            OPC_JALR[6:2], OPC_LOAD[6:2], OPC_OP_IMM[6:2]: fmt_o = I_TYPE;
            OPC_STORE[6:2]:                               fmt_o = S_TYPE;
            OPC_BRANCH[6:2]:                              fmt_o = B_TYPE;
            OPC_LUI[6:2], OPC_AUIPC[6:2]:                 fmt_o = U_TYPE;
            OPC_JAL[6:2]:                                 fmt_o = J_TYPE;
            default:                                      fmt_o = R_TYPE;
        endcase
    end

    // Exception flag and operation code must agree on every word
    illegal_matches_op: assert final (illegal_o == (op_o == INVALID));

endmodule

`default_nettype wire

//--- source/imm_gen.sv
// Immediate generator: sign-extended immediate for the decoded instruction format
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import decode_pkg::*;
(
    input  instr_u          instr_i,
    input  fmt_e            fmt_i,
    output logic [XLEN-1:0] imm_o
);

    logic [XLEN-1:0] imm_i_fmt;
    logic [XLEN-1:0] imm_s_fmt;
    logic [XLEN-1:0] imm_b_fmt;
    logic [XLEN-1:0] imm_u_fmt;
    logic [XLEN-1:0] imm_j_fmt;

    // Bit 31 is the sign in every layout
    assign imm_i_fmt = {{(XLEN-12){instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
    assign imm_s_fmt = {{(XLEN-12){instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5,
                        instr_i.s.imm_4_0};
    assign imm_b_fmt = {{(XLEN-13){instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                        instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign imm_u_fmt = {instr_i.u.imm_31_12, 12'b0};
    assign imm_j_fmt = {{(XLEN-21){instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                        instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

    always_comb begin
        unique case (fmt_i)
            I_TYPE:  imm_o = imm_i_fmt;
            S_TYPE:  imm_o = imm_s_fmt;
            B_TYPE:  imm_o = imm_b_fmt;
            U_TYPE:  imm_o = imm_u_fmt;
            J_TYPE:  imm_o = imm_j_fmt;
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
// Hazard unit: destination and store locks, raises the read-after-write hazard level
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_i,
    input  instr_u                instr_i,
    input  fmt_e                  fmt_i,
    output logic                  hazard_o,
    output logic [REG_ADDR_W-1:0] rd_o
);

    logic [REG_ADDR_W-1:0] locked_reg;
    logic                  locked_store;
    logic                  is_load;
    logic                  is_store;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  hit_rs1;
    logic                  hit_rs2;

    assign is_load  = (instr_i.r.opcode[6:2] == OPC_LOAD[6:2]);
    assign is_store = (instr_i.r.opcode[6:2] == OPC_STORE[6:2]);

    // A hazard drops both locks, the replay then runs free
    always_ff @(posedge clk) begin
        if (reset) begin
            locked_reg   <= '0;
            locked_store <= 1'b0;
        end else if (hazard_o) begin
            locked_reg   <= '0;
            locked_store <= 1'b0;
        end else if (enable_i) begin
            locked_reg   <= instr_i.r.rd;
            locked_store <= is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_o <= '0;
        end else begin
            rd_o <= locked_reg;
        end
    end

    // CSR immediate forms decode as R and still compare the rs1 field.
    // That gives a rare false hazard, left as is
    assign use_rs1 = (fmt_i == R_TYPE) || (fmt_i == B_TYPE) || (fmt_i == S_TYPE) ||
                     (fmt_i == I_TYPE);
    assign use_rs2 = (fmt_i == R_TYPE) || (fmt_i == B_TYPE) || (fmt_i == S_TYPE);

    assign hit_rs1 = use_rs1 && (instr_i.r.rs1 != '0) && (instr_i.r.rs1 == locked_reg);
    assign hit_rs2 = use_rs2 && (instr_i.r.rs2 != '0) && (instr_i.r.rs2 == locked_reg);

    assign hazard_o = (hit_rs1 | hit_rs2 | (locked_store & is_load)) & enable_i;

    // The replay after a hazard always goes through
    replay_never_hazards: assert property (
        @(posedge clk) disable iff (reset) hazard_o |=> !hazard_o
    );

endmodule

`default_nettype wire

//--- source/issue_register.sv
// Issue register: operand selection and the registered decode result, bubble or hold
`timescale 1ns/1ps
`default_nettype none

module issue_register
    import decode_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            enable_i,
    input  logic            hazard_i,
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic [XLEN-1:0] imm_i,
    input  fmt_e            fmt_i,
    input  iop_e            op_i,
    input  logic            illegal_i,
    input  logic            access_fault_i,
    output decode_out_t     out_o
);

    decode_out_t next_out;
    decode_out_t bubble;

    always_comb begin
        bubble    = '0;
        bubble.op = NOP;
    end

    ////////////////////////////////////////
    // Operand select by format
    ////////////////////////////////////////

    always_comb begin
        next_out.first_operand  = (fmt_i == U_TYPE || fmt_i == J_TYPE) ? pc_i : rs1_data_i;
        next_out.second_operand = (fmt_i == R_TYPE) ? rs2_data_i : imm_i;
        next_out.third_operand  = (fmt_i == S_TYPE) ? rs2_data_i : imm_i;
        next_out.pc             = pc_i;
        next_out.instruction    = instr_i;
        next_out.op             = op_i;
        next_out.exc_illegal    = illegal_i;
        next_out.exc_misaligned = (pc_i[1:0] != 2'b00);
        next_out.exc_access_fault = access_fault_i;
    end

    // Reset and hazard both leave a NOP behind
    always_ff @(posedge clk) begin
        if (reset || hazard_i) begin
            out_o <= bubble;
        end else if (enable_i) begin
            out_o <= next_out;
        end
    end

    bubble_after_hazard: assert property (
        @(posedge clk) disable iff (reset) hazard_i |=> (out_o.op == NOP)
    );

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// Decode stage top: replay of the held instruction and wiring of decoder, immediate, hazard, issue
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_i,
    input  logic [XLEN-1:0]       instruction_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic                  access_fault_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  hazard_o,
    output decode_out_t           out_o
);

    instr_u          instruction;
    instr_u          last_instruction;
    logic            last_hazard;
    logic            last_stall;
    iop_e            op;
    fmt_e            fmt;
    logic            illegal;
    logic [XLEN-1:0] imm;

    ////////////////////////////////////////
    // Replay after hazard or stall
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        last_instruction <= instruction;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hazard <= 1'b0;
            last_stall  <= 1'b0;
        end else begin
            last_hazard <= hazard_o;
            last_stall  <= ~enable_i;
        end
    end

    assign instruction = (last_hazard || last_stall) ? last_instruction : instruction_i;

    // Register file addresses go out in the same cycle
    assign rs1_o = instruction.r.rs1;
    assign rs2_o = instruction.r.rs2;

    op_decoder u_op_decoder (
        .instr_i   (instruction),
        .op_o      (op),
        .fmt_o     (fmt),
        .illegal_o (illegal)
    );

    imm_gen u_imm_gen (
        .instr_i (instruction),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    hazard_unit u_hazard_unit (
        .clk      (clk),
        .reset    (reset),
        .enable_i (enable_i),
        .instr_i  (instruction),
        .fmt_i    (fmt),
        .hazard_o (hazard_o),
        .rd_o     (rd_o)
    );

    issue_register u_issue_register (
        .clk            (clk),
        .reset          (reset),
        .enable_i       (enable_i),
        .hazard_i       (hazard_o),
        .instr_i        (instruction),
        .pc_i           (pc_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .imm_i          (imm),
        .fmt_i          (fmt),
        .op_i           (op),
        .illegal_i      (illegal),
        .access_fault_i (access_fault_i),
        .out_o          (out_o)
    );

endmodule

`default_nettype wire

//--- tb/decode_vectors.svh
// Decode stage test vectors: one row per clock with stimulus and expected decode
// Columns: enable, instruction, pc, access fault, hazard, op, format, immediate
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

task automatic load_vectors();
    // Register forms, M extension and I-type immediates
    add_row(1'b1, 32'h002081B3, 32'h00001000, 1'b0, 1'b0, ADD,     R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h407302B3, 32'h00001004, 1'b0, 1'b0, SUB,     R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h02A48433, 32'h00001008, 1'b0, 1'b0, MUL,     R_TYPE, 32'h00000000);
    add_row(1'b1, 32'hFFB60593, 32'h0000100C, 1'b0, 1'b0, ADD,     I_TYPE, 32'hFFFFFFFB);
    add_row(1'b1, 32'h40775693, 32'h00001010, 1'b0, 1'b0, SRA,     I_TYPE, 32'h00000407);
    // Upper immediates and jumps take the pc as first operand
    add_row(1'b1, 32'hABCDE7B7, 32'h00001014, 1'b0, 1'b0, LUI,     U_TYPE, 32'hABCDE000);
    add_row(1'b1, 32'h12345817, 32'h00001018, 1'b0, 1'b0, ADD,     U_TYPE, 32'h12345000);
    add_row(1'b1, 32'hFF1FF0EF, 32'h0000101C, 1'b0, 1'b0, JAL,     J_TYPE, 32'hFFFFFFF0);
    add_row(1'b1, 32'h305918F3, 32'h00001020, 1'b0, 1'b0, CSRRW,   R_TYPE, 32'h00000000);
    // Load right after a store, then the replay
    add_row(1'b1, 32'hFF3A2C23, 32'h00001024, 1'b0, 1'b0, SW,      S_TYPE, 32'hFFFFFFF8);
    add_row(1'b1, 32'h00CB2A83, 32'h00001028, 1'b0, 1'b1, LW,      I_TYPE, 32'h0000000C);
    add_row(1'b1, 32'h00CB2A83, 32'h00001028, 1'b0, 1'b0, LW,      I_TYPE, 32'h0000000C);
    // Reads the rd of the load
    add_row(1'b1, 32'h004A8BB3, 32'h0000102C, 1'b0, 1'b1, ADD,     R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h004A8BB3, 32'h0000102C, 1'b0, 1'b0, ADD,     R_TYPE, 32'h00000000);
    // x0 sources against a lock of x0
    add_row(1'b1, 32'h001C0013, 32'h00001030, 1'b0, 1'b0, ADD,     I_TYPE, 32'h00000001);
    add_row(1'b1, 32'h00000D33, 32'h00001034, 1'b0, 1'b0, ADD,     R_TYPE, 32'h00000000);
    add_row(1'b1, 32'hFFBD10E3, 32'h00001038, 1'b0, 1'b1, BNE,     B_TYPE, 32'hFFFFFFE0);
    add_row(1'b1, 32'hFFBD10E3, 32'h00001038, 1'b0, 1'b0, BNE,     B_TYPE, 32'hFFFFFFE0);
    add_row(1'b1, 32'h07DE7263, 32'h0000103C, 1'b0, 1'b0, BGEU,    B_TYPE, 32'h00000064);
    add_row(1'b1, 32'h13EF81A3, 32'h00001040, 1'b0, 1'b0, SB,      S_TYPE, 32'h00000123);
    // Misaligned pc, then unknown opcode with an access fault
    add_row(1'b1, 32'h7FF08293, 32'h00001046, 1'b0, 1'b0, ADD,     I_TYPE, 32'h000007FF);
    add_row(1'b1, 32'h0031032B, 32'h00001048, 1'b1, 1'b0, INVALID, R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h022180D7, 32'h0000104C, 1'b0, 1'b0, INVALID, R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h207404B3, 32'h00001050, 1'b0, 1'b0, INVALID, R_TYPE, 32'h00000000);
    // Two stalled cycles on a reader of x10, the instruction is held upstream
    add_row(1'b1, 32'h00C58533, 32'h00001054, 1'b0, 1'b0, ADD,     R_TYPE, 32'h00000000);
    add_row(1'b0, 32'h01054733, 32'h00001058, 1'b0, 1'b0, XOR,     R_TYPE, 32'h00000000);
    add_row(1'b0, 32'h01054733, 32'h00001058, 1'b0, 1'b0, XOR,     R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h01054733, 32'h00001058, 1'b0, 1'b1, XOR,     R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h01054733, 32'h00001058, 1'b0, 1'b0, XOR,     R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h00100073, 32'h0000105C, 1'b0, 1'b0, EBREAK,  R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h0FF0000F, 32'h00001060, 1'b0, 1'b0, NOP,     R_TYPE, 32'h00000000);
    add_row(1'b1, 32'h01018167, 32'h00001064, 1'b0, 1'b0, JALR,    I_TYPE, 32'h00000010);
    add_row(1'b1, 32'hFFF14203, 32'h00001068, 1'b0, 1'b1, LBU,     I_TYPE, 32'hFFFFFFFF);
    add_row(1'b1, 32'hFFF14203, 32'h00001068, 1'b0, 1'b0, LBU,     I_TYPE, 32'hFFFFFFFF);
    add_row(1'b1, 32'h0010006F, 32'h0000106C, 1'b0, 1'b0, JAL,     J_TYPE, 32'h00000800);
    add_row(1'b1, 32'h0283B333, 32'h00001070, 1'b0, 1'b0, MULHU,   R_TYPE, 32'h00000000);
endtask

`endif

//--- tb/decode_tb.sv
// Decode stage testbench: table-driven stimulus, register file model and output checks
`timescale 1ns/1ps
`default_nettype none

module decode_tb
    import decode_pkg::*;
();

    localparam int          HALF_PERIOD = 20;
    localparam logic [31:0] SEED        = 32'hd828;
    // addi x0, x0, 0
    localparam logic [31:0] IDLE_WORD   = 32'h00000013;

    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic            fault;
        logic            hazard;
        iop_e            op;
        fmt_e            fmt;
        logic [XLEN-1:0] imm;
    } vector_t;

    logic                  clk;
    logic                  reset;
    logic                  enable;
    logic [XLEN-1:0]       instruction;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  access_fault;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  hazard;
    decode_out_t           dut_out;

    logic [XLEN-1:0] reg_model [32];
    vector_t         vectors [$];
    int              errors;
    int              checks;
    int              cycles;
    int              cycle_limit;

    task automatic add_row(input logic en, input logic [31:0] instr, input logic [31:0] pc_val,
                           input logic fault, input logic hz, input iop_e op, input fmt_e fmt,
                           input logic [31:0] imm);
        vectors.push_back(vector_t'{en, instr, pc_val, fault, hz, op, fmt, imm});
    endtask

    `include "decode_vectors.svh"

    decode_stage UUT (
        .clk            (clk),
        .reset          (reset),
        .enable_i       (enable),
        .instruction_i  (instruction),
        .pc_i           (pc),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .access_fault_i (access_fault),
        .rs1_o          (rs1_addr),
        .rs2_o          (rs2_addr),
        .rd_o           (rd_addr),
        .hazard_o       (hazard),
        .out_o          (dut_out)
    );

    // Register file answers in the same cycle
    assign rs1_data = reg_model[rs1_addr];
    assign rs2_data = reg_model[rs2_addr];

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("TIMEOUT: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic check_output(input decode_out_t expected);
        compare_word("out_o.op", 32'(expected.op), 32'(dut_out.op));
        compare_word("out_o.first_operand", expected.first_operand, dut_out.first_operand);
        compare_word("out_o.second_operand", expected.second_operand, dut_out.second_operand);
        compare_word("out_o.third_operand", expected.third_operand, dut_out.third_operand);
        compare_word("out_o.pc", expected.pc, dut_out.pc);
        compare_word("out_o.instruction", expected.instruction, dut_out.instruction);
        compare_word("out_o.exc_illegal", 32'(expected.exc_illegal),
                     32'(dut_out.exc_illegal));
        compare_word("out_o.exc_misaligned", 32'(expected.exc_misaligned),
                     32'(dut_out.exc_misaligned));
        compare_word("out_o.exc_access_fault", 32'(expected.exc_access_fault),
                     32'(dut_out.exc_access_fault));
    endtask

    // Hazard rows leave a bubble, the others the decoded word
    function automatic decode_out_t expected_out(input vector_t row);
        decode_out_t     result;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        rs1_val   = reg_model[row.instr[19:15]];
        rs2_val   = reg_model[row.instr[24:20]];
        result    = '0;
        result.op = NOP;
        if (!row.hazard) begin
            result.first_operand    = (row.fmt == U_TYPE || row.fmt == J_TYPE) ? row.pc
                                                                              : rs1_val;
            result.second_operand   = (row.fmt == R_TYPE) ? rs2_val : row.imm;
            result.third_operand    = (row.fmt == S_TYPE) ? rs2_val : row.imm;
            result.pc               = row.pc;
            result.instruction      = row.instr;
            result.op               = row.op;
            result.exc_illegal      = (row.op == INVALID);
            result.exc_misaligned   = (row.pc[1:0] != 2'b00);
            result.exc_access_fault = row.fault;
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        decode_out_t           expect_prev;
        decode_out_t           idle_out;
        vector_t               row;
        logic [REG_ADDR_W-1:0] lock_in;
        logic [REG_ADDR_W-1:0] rd_now;
        errors = 0;
        checks = 0;
        cycles = 0;
        void'($urandom(SEED));
        reg_model[0] = '0;
        for (int r = 1; r < 32; r++) begin
            reg_model[r] = $urandom;
        end
        load_vectors();
        cycle_limit  = 2 * vectors.size() + 20;
        reset        = 1'b1;
        enable       = 1'b1;
        instruction  = IDLE_WORD;
        pc           = '0;
        access_fault = 1'b0;
        lock_in      = '0;
        rd_now       = '0;
        expect_prev  = '0;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        idle_out    = '0;
        idle_out.op = NOP;
        check_output(idle_out);
        compare_word("hazard_o", 32'h0, 32'(hazard));

        for (int i = 0; i < vectors.size(); i++) begin
            row = vectors[i];
            @(posedge clk);
            enable       <= row.en;
            instruction  <= row.instr;
            pc           <= row.pc;
            access_fault <= row.fault;
            @(negedge clk);
            compare_word("hazard_o", 32'(row.hazard), 32'(hazard));
            compare_word("rd_o", 32'(rd_now), 32'(rd_addr));
            compare_word("rs1_o", 32'(row.instr[19:15]), 32'(rs1_addr));
            compare_word("rs2_o", 32'(row.instr[24:20]), 32'(rs2_addr));
            if (i > 0) begin
                check_output(expect_prev);
            end
            // A stalled row keeps the previous result
            if (row.en) begin
                expect_prev = expected_out(row);
            end
            rd_now = lock_in;
            if (row.hazard) begin
                lock_in = '0;
            end else if (row.en) begin
                lock_in = row.instr[11:7];
            end
        end

        @(posedge clk);
        enable      <= 1'b0;
        instruction <= IDLE_WORD;
        @(negedge clk);
        check_output(expect_prev);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+tb
source/decode_pkg.sv
source/op_decoder.sv
source/imm_gen.sv
source/hazard_unit.sv
source/issue_register.sv
source/decode_stage.sv
tb/decode_tb.sv

//--- Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
